// File: files.f
rtl/umi_pkg.sv
rtl/umi_unpack.sv
rtl/umi_pack.sv
rtl/umiram_mem.sv
rtl/umiram_ctrl.sv
rtl/umiram.sv
tests/umiram_tb.sv

// File: Makefile
TOP := umiram_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// File: tests/umiram_tb.sv
`timescale 1ns/1ns

module umiram_tb;
    import umi_pkg::*;

    localparam int ADDR_WIDTH = 6;
    localparam int DATA_WIDTH = 32;
    localparam int WORDS      = 2 ** ADDR_WIDTH;
    localparam int WAIT_LIMIT = 500;

    logic        clk;
    logic        arst_n;
    umi_packet_t rx_packet;
    logic        rx_valid;
    logic        rx_ready;
    umi_packet_t tx_packet;
    logic        tx_valid;
    logic        tx_ready;

    // reference memory and the responses still owed by the DUT
    logic [DATA_WIDTH-1:0] model [WORDS];
    bit                    written [WORDS];
    umi_packet_t           exp_q [$];

    logic [31:0] rng;
    logic [31:0] stall_rng;
    logic        stall_on;
    int          errors;
    int          timeouts;
    int          resp_expected;
    int          resp_seen;

    umiram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_packet (rx_packet),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .tx_packet (tx_packet),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng = next_rand(rng);
        return rng;
    endfunction

    // random bits above the word index exercise the address aliasing
    function automatic umi_addr_t random_addr(input int idx);
        logic [31:0] hi;
        logic [31:0] mid;
        hi  = draw();
        mid = draw();
        return {hi, mid[25:0], idx[5:0]};
    endfunction

    function automatic umi_packet_t request_packet(input umi_opcode_t op,
                                                   input umi_addr_t dst,
                                                   input umi_addr_t src,
                                                   input umi_data_t data);
        umi_packet_t pkt;
        pkt = '0;
        pkt[7:0]     = op;
        pkt[11:8]    = 4'd2;
        pkt[95:32]   = dst;
        pkt[159:96]  = src;
        pkt[255:160] = data;
        return pkt;
    endfunction

    // size 2 is log2 of four bytes per word and user stays zero
    function automatic umi_packet_t response_packet(input umi_opcode_t op,
                                                    input umi_addr_t dst,
                                                    input umi_addr_t src,
                                                    input logic [31:0] word);
        umi_packet_t pkt;
        pkt = '0;
        pkt[7:0]     = op;
        pkt[11:8]    = 4'd2;
        pkt[95:32]   = dst;
        pkt[159:96]  = src;
        pkt[255:160] = {64'd0, word};
        return pkt;
    endfunction

    task automatic finish_run();
        $display("errors: %0d  timeouts: %0d  responses: %0d of %0d",
                 errors, timeouts, resp_seen, resp_expected);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_packet(input umi_packet_t pkt);
        int waited;
        waited    = 0;
        rx_packet = pkt;
        rx_valid  = 1'b1;
        @(negedge clk);
        while (!rx_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!rx_ready) begin
            timeouts++;
            $display("receive channel stayed busy, request was never accepted at %0t", $time);
            finish_run();
        end else begin
            @(posedge clk);
            #1;
            rx_valid  = 1'b0;
            rx_packet = '0;
        end
    endtask

    task automatic write_posted(input int idx);
        umi_data_t data;
        data = {draw(), draw(), draw()};
        model[idx]   = data[31:0];
        written[idx] = 1'b1;
        send_packet(request_packet(OP_WRITE_POSTED, random_addr(idx), {draw(), draw()}, data));
    endtask

    task automatic write_acked(input int idx);
        umi_data_t data;
        umi_addr_t dst;
        umi_addr_t src;
        data = {draw(), draw(), draw()};
        dst  = random_addr(idx);
        src  = {draw(), draw()};
        model[idx]   = data[31:0];
        written[idx] = 1'b1;
        exp_q.push_back(response_packet(OP_RESP_ACK, src, dst, 32'd0));
        resp_expected++;
        send_packet(request_packet(OP_WRITE_ACK, dst, src, data));
    endtask

    task automatic read_word(input int idx);
        umi_addr_t dst;
        umi_addr_t src;
        // never read a word the model does not know
        if (!written[idx]) begin
            write_posted(idx);
        end
        dst = random_addr(idx);
        src = {draw(), draw()};
        exp_q.push_back(response_packet(OP_RESP_READ, src, dst, model[idx]));
        resp_expected++;
        send_packet(request_packet(OP_READ, dst, src, {draw(), draw(), draw()}));
    endtask

    task automatic send_unknown(input int idx);
        umi_opcode_t op;
        op = umi_opcode_t'(draw());
        if (op == OP_READ || op == OP_WRITE_POSTED || op == OP_WRITE_ACK) begin
            op = 8'h7f;
        end
        send_packet(request_packet(op, random_addr(idx), {draw(), draw()},
                                   {draw(), draw(), draw()}));
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        #1;
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("%0d responses never came out of the DUT", exp_q.size());
            finish_run();
        end
    endtask

    // consumer with random back-pressure when enabled
    always @(posedge clk) begin
        #1;
        stall_rng = next_rand(stall_rng);
        tx_ready  = stall_on ? stall_rng[4] : 1'b1;
    end

    // every transmit transfer against the oldest expected response
    always @(posedge clk) begin
        umi_packet_t exp_pkt;
        if (arst_n && tx_valid && tx_ready) begin
            resp_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t: response with no pending request, opcode %h",
                         $time, tx_packet[7:0]);
            end else begin
                exp_pkt = exp_q.pop_front();
                assert (tx_packet == exp_pkt) else begin
                    errors++;
                    $display("[ERROR] %0t: response %h, expected %h", $time, tx_packet, exp_pkt);
                end
            end
        end
    end

    assert property (@(posedge clk) !arst_n |-> !tx_valid) else begin
        errors++;
        $display("[ERROR] %0t: tx_valid high during reset", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
                     tx_valid && !tx_ready |=> tx_valid && $stable(tx_packet)) else begin
        errors++;
        $display("[ERROR] %0t: response changed or dropped under back-pressure", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n) tx_valid |-> !rx_ready) else begin
        errors++;
        $display("[ERROR] %0t: rx_ready high while a response is pending", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
                     tx_valid && tx_ready |=> rx_ready) else begin
        errors++;
        $display("[ERROR] %0t: rx_ready low after the transmit transfer", $time);
    end

    initial begin
        int idx;
        int kind;
        clk = 1'b0;
        arst_n = 1'b0;
        rx_packet = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b1;
        stall_on = 1'b0;
        rng = 32'd65;
        stall_rng = 32'd65;
        errors = 0;
        timeouts = 0;
        resp_expected = 0;
        resp_seen = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!tx_valid && rx_ready) else begin
            errors++;
            $display("[ERROR] %0t: after reset tx_valid %b rx_ready %b", $time, tx_valid, rx_ready);
        end
        @(posedge clk);
        #1;
        // posted writes stream into every word before the reads
        for (int i = 0; i < WORDS; i++) begin
            write_posted(i);
        end
        for (int i = 0; i < 20; i++) begin
            read_word(draw() % WORDS);
        end
        for (int i = 0; i < 10; i++) begin
            idx = draw() % WORDS;
            write_acked(idx);
            read_word(idx);
        end
        // unknown opcodes must leave the model word in place
        for (int i = 0; i < 8; i++) begin
            idx = draw() % WORDS;
            send_unknown(idx);
            read_word(idx);
        end
        // random traffic with the consumer stalling
        stall_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            kind = draw() % 4;
            idx  = draw() % WORDS;
            case (kind)
                0: write_posted(idx);
                1: write_acked(idx);
                2: read_word(idx);
                default: send_unknown(idx);
            endcase
        end
        drain_responses();
        stall_on = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        assert (resp_seen == resp_expected) else begin
            errors++;
            $display("[ERROR] %0t: %0d responses seen, %0d expected", $time, resp_seen,
                     resp_expected);
        end
        finish_run();
    end

endmodule

// File: rtl/umiram.sv
`timescale 1ns/1ns

module umiram #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  umi_pkg::umi_packet_t rx_packet,
    input  logic                 rx_valid,
    output logic                 rx_ready,
    output umi_pkg::umi_packet_t tx_packet,
    output logic                 tx_valid,
    input  logic                 tx_ready
);
    import umi_pkg::*;

    // decoded request
    umi_addr_t rx_dstaddr;
    umi_addr_t rx_srcaddr;
    umi_data_t rx_data;
    logic      cmd_read;
    logic      cmd_write_posted;
    logic      cmd_write_ack;

    // memory side
    logic                  mem_we;
    logic                  mem_re;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_rdata;

    // response side
    logic      resp_load;
    logic      resp_is_read;
    umi_addr_t resp_dstaddr;
    umi_addr_t resp_srcaddr;

    umi_unpack u_unpack (
        .packet           (rx_packet),
        .opcode           (),
        .dstaddr          (rx_dstaddr),
        .srcaddr          (rx_srcaddr),
        .data             (rx_data),
        .cmd_read         (cmd_read),
        .cmd_write_posted (cmd_write_posted),
        .cmd_write_ack    (cmd_write_ack)
    );

    umiram_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk              (clk),
        .arst_n           (arst_n),
        .rx_valid         (rx_valid),
        .rx_ready         (rx_ready),
        .cmd_read         (cmd_read),
        .cmd_write_posted (cmd_write_posted),
        .cmd_write_ack    (cmd_write_ack),
        .rx_dstaddr       (rx_dstaddr),
        .rx_srcaddr       (rx_srcaddr),
        .mem_we           (mem_we),
        .mem_re           (mem_re),
        .mem_addr         (mem_addr),
        .resp_load        (resp_load),
        .resp_is_read     (resp_is_read),
        .resp_dstaddr     (resp_dstaddr),
        .resp_srcaddr     (resp_srcaddr),
        .tx_valid         (tx_valid),
        .tx_ready         (tx_ready)
    );

    umiram_mem #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mem (
        .clk   (clk),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (rx_data),
        .rdata (mem_rdata)
    );

    umi_pack #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_pack (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (resp_load),
        .is_read (resp_is_read),
        .dstaddr (resp_dstaddr),
        .srcaddr (resp_srcaddr),
        .rd_word (mem_rdata),
        .packet  (tx_packet)
    );

endmodule

// File: rtl/umiram_ctrl.sv
`timescale 1ns/1ns

module umiram_ctrl #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    input  logic                  cmd_read,
    input  logic                  cmd_write_posted,
    input  logic                  cmd_write_ack,
    input  umi_pkg::umi_addr_t    rx_dstaddr,
    input  umi_pkg::umi_addr_t    rx_srcaddr,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  resp_load,
    output logic                  resp_is_read,
    output umi_pkg::umi_addr_t    resp_dstaddr,
    output umi_pkg::umi_addr_t    resp_srcaddr,
    output logic                  tx_valid,
    input  logic                  tx_ready
);
    import umi_pkg::*;

    ram_state_e state;
    ram_state_e state_next;

    logic rx_fire;
    logic needs_resp;

    // receive handshake
    assign rx_ready   = (state == ST_IDLE);
    assign rx_fire    = rx_valid && rx_ready;
    assign needs_resp = cmd_read || cmd_write_ack;

    // memory strobes straight from the accepted request
    // upper address bits are ignored
    assign mem_we   = rx_fire && (cmd_write_posted || cmd_write_ack);
    assign mem_re   = rx_fire && cmd_read;
    assign mem_addr = rx_dstaddr[ADDR_WIDTH-1:0];

    // read word is valid one cycle after acceptance
    assign resp_load = (state == ST_READ);
    assign tx_valid  = (state == ST_RESP);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // posted writes and unknown opcodes stay here
                if (rx_fire && needs_resp) begin
                    state_next = ST_READ;
                end
            end
            ST_READ: begin
                state_next = ST_RESP;
            end
            ST_RESP: begin
                if (tx_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // response goes back to the requester, source and destination swap
    always_ff @(posedge clk) begin
        if (rx_fire && needs_resp) begin
            resp_dstaddr <= rx_srcaddr;
            resp_srcaddr <= rx_dstaddr;
            resp_is_read <= cmd_read;
        end
    end

endmodule

// File: rtl/umiram_mem.sv
`timescale 1ns/1ns

module umiram_mem #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic                  re,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  umi_pkg::umi_data_t    wdata,
    output logic [DATA_WIDTH-1:0] rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // word storage, contents undefined until written
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // only the low word bits of the data field are kept
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata[DATA_WIDTH-1:0];
        end
    end

    // registered read, rdata holds between reads
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: rtl/umi_pack.sv
`timescale 1ns/1ns

module umi_pack #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load,
    input  logic                  is_read,
    input  umi_pkg::umi_addr_t    dstaddr,
    input  umi_pkg::umi_addr_t    srcaddr,
    input  logic [DATA_WIDTH-1:0] rd_word,
    output umi_pkg::umi_packet_t  packet
);
    import umi_pkg::*;

    // log2 of bytes per word
    localparam umi_size_t RESP_SIZE = umi_size_t'($clog2(DATA_WIDTH / 8));

    umi_packet_t next_packet;
    umi_data_t   resp_data;

    // zero-extended word for reads, zero for acks
    assign resp_data = is_read ? umi_data_t'(rd_word) : '0;

    always_comb begin
        next_packet = '0;
        next_packet[UMI_OPCODE_LSB +: $bits(umi_opcode_t)] =
            is_read ? OP_RESP_READ : OP_RESP_ACK;
        next_packet[UMI_SIZE_LSB +: $bits(umi_size_t)] = RESP_SIZE;
        next_packet[UMI_USER_LSB +: $bits(umi_user_t)] = '0;
        next_packet[UMI_DST_LSB +: $bits(umi_addr_t)]  = dstaddr;
        next_packet[UMI_SRC_LSB +: $bits(umi_addr_t)]  = srcaddr;
        next_packet[UMI_DATA_LSB +: $bits(umi_data_t)] = resp_data;
    end

    // response register, held until the next load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet <= '0;
        end else if (load) begin
            packet <= next_packet;
        end
    end

endmodule

// File: rtl/umi_unpack.sv
`timescale 1ns/1ns

module umi_unpack (
    input  umi_pkg::umi_packet_t packet,
    output umi_pkg::umi_opcode_t opcode,
    output umi_pkg::umi_addr_t   dstaddr,
    output umi_pkg::umi_addr_t   srcaddr,
    output umi_pkg::umi_data_t   data,
    output logic                 cmd_read,
    output logic                 cmd_write_posted,
    output logic                 cmd_write_ack
);
    import umi_pkg::*;

    // field slicing
    assign opcode  = packet[UMI_OPCODE_LSB +: $bits(umi_opcode_t)];
    assign dstaddr = packet[UMI_DST_LSB +: $bits(umi_addr_t)];
    assign srcaddr = packet[UMI_SRC_LSB +: $bits(umi_addr_t)];
    assign data    = packet[UMI_DATA_LSB +: $bits(umi_data_t)];

    // request kind, anything else decodes to no command
    assign cmd_read         = (opcode == OP_READ);
    assign cmd_write_posted = (opcode == OP_WRITE_POSTED);
    assign cmd_write_ack    = (opcode == OP_WRITE_ACK);

endmodule

// File: rtl/umi_pkg.sv
package umi_pkg;

    // whole transaction packet
    typedef logic [255:0] umi_packet_t;

    // field types
    typedef logic [7:0]  umi_opcode_t;
    typedef logic [3:0]  umi_size_t;
    typedef logic [19:0] umi_user_t;
    typedef logic [63:0] umi_addr_t;
    typedef logic [95:0] umi_data_t;

    // field positions inside the packet
    localparam int UMI_OPCODE_LSB = 0;
    localparam int UMI_SIZE_LSB   = 8;
    localparam int UMI_USER_LSB   = 12;
    localparam int UMI_DST_LSB    = 32;
    localparam int UMI_SRC_LSB    = 96;
    localparam int UMI_DATA_LSB   = 160;

    // request opcodes
    localparam umi_opcode_t OP_READ         = 8'h08;
    localparam umi_opcode_t OP_WRITE_POSTED = 8'h01;
    localparam umi_opcode_t OP_WRITE_ACK    = 8'h05;

    // response opcodes
    localparam umi_opcode_t OP_RESP_READ    = 8'h02;
    localparam umi_opcode_t OP_RESP_ACK     = 8'h06;

    // endpoint controller states
    typedef enum logic [1:0] {
        // waiting for a request
        ST_IDLE = 2'd0,
        // response being formed, memory word in flight
        ST_READ = 2'd1,
        // response offered on the transmit channel
        ST_RESP = 2'd2
    } ram_state_e;

endpackage
